// File: src/ejtag_pkg.sv
`default_nettype none

package ejtag_pkg;

  typedef logic [31:0] word_t;
  typedef logic [5:0]  reg_addr_t;
  typedef logic [4:0]  ir_t;

  // Word offsets into the debug register window.
  localparam reg_addr_t reg_id           = 6'h00;
  localparam reg_addr_t reg_probe_data   = 6'h01;
  localparam reg_addr_t reg_probe_status = 6'h02;
  localparam reg_addr_t reg_ibs          = 6'h10;
  localparam reg_addr_t reg_ib_base      = 6'h20;

  localparam int unsigned ib_stride    = 4;
  localparam int unsigned ib_slot_addr = 0;
  localparam int unsigned ib_slot_mask = 1;
  localparam int unsigned ib_slot_ctl  = 2;

  localparam int unsigned ibc_bit_en    = 0;
  localparam int unsigned ibc_bit_break = 1;
  localparam int unsigned ibc_bit_trace = 2;

  localparam ir_t ir_idcode  = 5'h01;
  localparam ir_t ir_data    = 5'h09;
  localparam ir_t ir_control = 5'h0A;

  localparam word_t ejtag_idcode = 32'h1eb3_1001;
  localparam int unsigned num_ibrk = 2;

  localparam int unsigned ctl_bit_probe_en = 0;
  localparam int unsigned ctl_bit_dint     = 1;

  // Offset of one slot of a breakpoint channel.
  function automatic reg_addr_t ib_reg(input int unsigned ch, input int unsigned slot);
    return reg_addr_t'(reg_ib_base + ib_stride * ch + slot);
  endfunction

endpackage

`default_nettype wire

// File: src/ejtag_scan.sv
`default_nettype none

module ejtag_scan (
  input  logic               core_clock,
  input  logic               rst,
  input  ejtag_pkg::ir_t     jtag_ir,
  input  logic               tap_capture,
  input  logic               tap_shift,
  input  logic               tap_update,
  input  logic               tdi,
  input  logic               bus_valid,
  input  logic               bus_write,
  input  ejtag_pkg::reg_addr_t bus_addr,
  input  ejtag_pkg::word_t   bus_wdata,
  output logic               tdo,
  output ejtag_pkg::word_t   probe_to_core,
  output ejtag_pkg::word_t   control,
  output logic               probe_en,
  output logic               debug_int
);

  import ejtag_pkg::*;

  word_t shift_q;
  logic  bypass_q;
  word_t core_to_probe;

  logic sel_idcode;
  logic sel_data;
  logic sel_control;
  logic sel_bypass;
  logic mbox_wr;

  assign sel_idcode  = (jtag_ir == ir_idcode);
  assign sel_data    = (jtag_ir == ir_data);
  assign sel_control = (jtag_ir == ir_control);
  assign sel_bypass  = !(sel_idcode || sel_data || sel_control);

  assign mbox_wr = bus_valid && bus_write && (bus_addr == reg_probe_data);

  // Core writes fill the mailbox that the probe captures through DATA.
  always_ff @(posedge core_clock) begin
    if (rst) begin
      core_to_probe <= '0;
    end else if (mbox_wr) begin
      core_to_probe <= bus_wdata;
    end
  end

  // The 32-bit chain is shared by IDCODE, DATA and CONTROL.
  always_ff @(posedge core_clock) begin
    if (rst) begin
      shift_q  <= '0;
      bypass_q <= 1'b0;
    end else if (tap_capture) begin
      if (sel_idcode) begin
        shift_q <= ejtag_idcode;
      end else if (sel_data) begin
        shift_q <= core_to_probe;
      end else if (sel_control) begin
        shift_q <= control;
      end else begin
        bypass_q <= 1'b0;
      end
    end else if (tap_shift) begin
      if (sel_bypass) begin
        bypass_q <= tdi;
      end else begin
        shift_q <= {tdi, shift_q[31:1]};
      end
    end
  end

  // Update only lands in the writable registers.
  always_ff @(posedge core_clock) begin
    if (rst) begin
      probe_to_core <= '0;
      control       <= '0;
    end else if (tap_update) begin
      if (sel_data) begin
        probe_to_core <= shift_q;
      end
      if (sel_control) begin
        control <= shift_q;
      end
    end
  end

  // BYPASS presents its own one-bit register on tdo.
  assign tdo = sel_bypass ? bypass_q : shift_q[0];

  assign probe_en  = control[ctl_bit_probe_en];
  assign debug_int = control[ctl_bit_dint];

endmodule

`default_nettype wire

// File: src/ejtag_pmatch.sv
`default_nettype none

module ejtag_pmatch (
  input  logic                 core_clock,
  input  logic                 rst,
  input  logic                 bus_valid,
  input  logic                 bus_write,
  input  ejtag_pkg::reg_addr_t bus_addr,
  input  ejtag_pkg::word_t     bus_wdata,
  input  logic                 fetch_valid,
  input  ejtag_pkg::word_t     fetch_addr,
  output ejtag_pkg::word_t     iba [ejtag_pkg::num_ibrk],
  output ejtag_pkg::word_t     ibm [ejtag_pkg::num_ibrk],
  output ejtag_pkg::word_t     ibc [ejtag_pkg::num_ibrk],
  output logic [ejtag_pkg::num_ibrk-1:0] ibs,
  output logic                 break_hit,
  output logic                 trace_hit
);

  import ejtag_pkg::*;

  logic                wr_en;
  logic [num_ibrk-1:0] ibs_clr;
  logic [num_ibrk-1:0] addr_match;
  logic [num_ibrk-1:0] break_match;
  logic [num_ibrk-1:0] trace_match;

  assign wr_en   = bus_valid && bus_write;
  assign ibs_clr = (wr_en && (bus_addr == reg_ibs)) ? bus_wdata[num_ibrk-1:0] : '0;

  // A mask bit of one turns the corresponding address bit into a don't care.
  always_comb begin
    for (int n = 0; n < num_ibrk; n++) begin
      addr_match[n]  = (((fetch_addr ^ iba[n]) & ~ibm[n]) == '0) && ibc[n][ibc_bit_en];
      break_match[n] = fetch_valid && addr_match[n] && ibc[n][ibc_bit_break];
      trace_match[n] = fetch_valid && addr_match[n] && ibc[n][ibc_bit_trace];
    end
  end

  always_ff @(posedge core_clock) begin
    if (rst) begin
      for (int n = 0; n < num_ibrk; n++) begin
        iba[n] <= '0;
        ibm[n] <= '0;
        ibc[n] <= '0;
      end
    end else if (wr_en) begin
      for (int n = 0; n < num_ibrk; n++) begin
        if (bus_addr == ib_reg(n, ib_slot_addr)) begin
          iba[n] <= bus_wdata;
        end
        if (bus_addr == ib_reg(n, ib_slot_mask)) begin
          ibm[n] <= bus_wdata;
        end
        if (bus_addr == ib_reg(n, ib_slot_ctl)) begin
          ibc[n] <= bus_wdata;
        end
      end
    end
  end

  // A new hit outranks a clear arriving on the same edge.
  always_ff @(posedge core_clock) begin
    if (rst) begin
      ibs       <= '0;
      break_hit <= 1'b0;
      trace_hit <= 1'b0;
    end else begin
      ibs       <= (ibs & ~ibs_clr) | break_match | trace_match;
      break_hit <= |break_match;
      trace_hit <= |trace_match;
    end
  end

endmodule

`default_nettype wire

// File: src/ejtag_dataout.sv
`default_nettype none

module ejtag_dataout (
  input  logic                 core_clock,
  input  logic                 rst,
  input  logic                 bus_valid,
  input  logic                 bus_write,
  input  ejtag_pkg::reg_addr_t bus_addr,
  input  ejtag_pkg::word_t     probe_to_core,
  input  ejtag_pkg::word_t     control,
  input  ejtag_pkg::word_t     iba [ejtag_pkg::num_ibrk],
  input  ejtag_pkg::word_t     ibm [ejtag_pkg::num_ibrk],
  input  ejtag_pkg::word_t     ibc [ejtag_pkg::num_ibrk],
  input  logic [ejtag_pkg::num_ibrk-1:0] ibs,
  output ejtag_pkg::word_t     bus_rdata,
  output logic                 bus_rvalid
);

  import ejtag_pkg::*;

  word_t rd_sel;
  logic  rd_en;

  assign rd_en = bus_valid && !bus_write;

  // Offsets that match nothing fall through as zero.
  always_comb begin
    rd_sel = '0;
    if (bus_addr == reg_id) begin
      rd_sel = ejtag_idcode;
    end else if (bus_addr == reg_probe_data) begin
      rd_sel = probe_to_core;
    end else if (bus_addr == reg_probe_status) begin
      rd_sel[0] = control[ctl_bit_probe_en];
      rd_sel[1] = control[ctl_bit_dint];
    end else if (bus_addr == reg_ibs) begin
      rd_sel[num_ibrk-1:0] = ibs;
    end
    for (int n = 0; n < num_ibrk; n++) begin
      if (bus_addr == ib_reg(n, ib_slot_addr)) begin
        rd_sel = iba[n];
      end else if (bus_addr == ib_reg(n, ib_slot_mask)) begin
        rd_sel = ibm[n];
      end else if (bus_addr == ib_reg(n, ib_slot_ctl)) begin
        rd_sel = ibc[n];
      end
    end
  end

  always_ff @(posedge core_clock) begin
    if (rst) begin
      bus_rvalid <= 1'b0;
    end else begin
      bus_rvalid <= rd_en;
    end
  end

  always_ff @(posedge core_clock) begin
    if (rd_en) begin
      bus_rdata <= rd_sel;
    end
  end

endmodule

`default_nettype wire

// File: src/ejtag.sv
`default_nettype none

module ejtag (
  input  logic                 core_clock,
  input  logic                 rst,
  input  logic                 bus_valid,
  input  logic                 bus_write,
  input  ejtag_pkg::reg_addr_t bus_addr,
  input  ejtag_pkg::word_t     bus_wdata,
  input  logic                 fetch_valid,
  input  ejtag_pkg::word_t     fetch_addr,
  input  ejtag_pkg::ir_t       jtag_ir,
  input  logic                 tap_capture,
  input  logic                 tap_shift,
  input  logic                 tap_update,
  input  logic                 tdi,
  output ejtag_pkg::word_t     bus_rdata,
  output logic                 bus_rvalid,
  output logic                 break_hit,
  output logic                 trace_hit,
  output logic                 tdo,
  output logic                 probe_en,
  output logic                 debug_int
);

  import ejtag_pkg::*;

  word_t               probe_to_core;
  word_t               control;
  word_t               iba [num_ibrk];
  word_t               ibm [num_ibrk];
  word_t               ibc [num_ibrk];
  logic [num_ibrk-1:0] ibs;

  ejtag_scan scan (
    .core_clock    (core_clock),
    .rst           (rst),
    .jtag_ir       (jtag_ir),
    .tap_capture   (tap_capture),
    .tap_shift     (tap_shift),
    .tap_update    (tap_update),
    .tdi           (tdi),
    .bus_valid     (bus_valid),
    .bus_write     (bus_write),
    .bus_addr      (bus_addr),
    .bus_wdata     (bus_wdata),
    .tdo           (tdo),
    .probe_to_core (probe_to_core),
    .control       (control),
    .probe_en      (probe_en),
    .debug_int     (debug_int)
  );

  ejtag_pmatch pmatch (
    .core_clock  (core_clock),
    .rst         (rst),
    .bus_valid   (bus_valid),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .iba         (iba),
    .ibm         (ibm),
    .ibc         (ibc),
    .ibs         (ibs),
    .break_hit   (break_hit),
    .trace_hit   (trace_hit)
  );

  ejtag_dataout dataout (
    .core_clock    (core_clock),
    .rst           (rst),
    .bus_valid     (bus_valid),
    .bus_write     (bus_write),
    .bus_addr      (bus_addr),
    .probe_to_core (probe_to_core),
    .control       (control),
    .iba           (iba),
    .ibm           (ibm),
    .ibc           (ibc),
    .ibs           (ibs),
    .bus_rdata     (bus_rdata),
    .bus_rvalid    (bus_rvalid)
  );

endmodule

`default_nettype wire

// File: bench/ejtag_tb.sv
`default_nettype none

module ejtag_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ejtag_pkg::*;

  localparam int num_fetch = 200;
  localparam int budget_cycles = 2 * (10 + 6 * 40 + 30 * 3 + num_fetch + 20);

  logic core_clock, rst, bus_valid, bus_write, fetch_valid;
  logic tap_capture, tap_shift, tap_update, tdi;
  logic bus_rvalid, break_hit, trace_hit, tdo, probe_en, debug_int;
  reg_addr_t bus_addr;
  word_t bus_wdata, fetch_addr, bus_rdata;
  ir_t jtag_ir;

  // Model of the register state, updated after each accepting edge.
  word_t model_iba [num_ibrk];
  word_t model_ibm [num_ibrk];
  word_t model_ibc [num_ibrk];
  logic [num_ibrk-1:0] model_ibs;
  word_t p2c, c2p, ctl;
  logic [1:0] exp_hit;
  word_t rng_state = 32'h5e8f8592;
  reg_addr_t unmapped [4] = '{6'h03, 6'h11, 6'h28, 6'h3f};

  ejtag ejtag_i (.*);

  initial core_clock = 1'b0;
  always #10 core_clock = ~core_clock;

  function automatic word_t xorshift(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Returns {trace, break} for channel n when a valid fetch hits addr.
  function automatic logic [1:0] chan_hit(input int n, input word_t addr);
    logic match;
    match = model_ibc[n][ibc_bit_en];
    for (int b = 0; b < 32; b++) begin
      if (!model_ibm[n][b] && addr[b] != model_iba[n][b]) match = 1'b0;
    end
    return {match && model_ibc[n][ibc_bit_trace], match && model_ibc[n][ibc_bit_break]};
  endfunction

  function automatic word_t reg_value(input reg_addr_t addr);
    int off;
    off = int'(addr) - int'(reg_ib_base);
    if (addr == reg_id) return ejtag_idcode;
    if (addr == reg_probe_data) return p2c;
    if (addr == reg_probe_status) return {30'b0, ctl[ctl_bit_dint], ctl[ctl_bit_probe_en]};
    if (addr == reg_ibs) return word_t'(model_ibs);
    if (off >= 0 && off / 4 < int'(num_ibrk)) begin
      case (off % 4)
        0: return model_iba[off / 4];
        1: return model_ibm[off / 4];
        2: return model_ibc[off / 4];
        default: return '0;
      endcase
    end
    return '0;
  endfunction

  task automatic check(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    int off;
    off = int'(addr) - int'(reg_ib_base);
    @(negedge core_clock);
    bus_valid = 1'b1;
    bus_write = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge core_clock);
    bus_valid = 1'b0;
    bus_write = 1'b0;
    if (addr == reg_probe_data) c2p = data;
    if (off >= 0 && off / 4 < int'(num_ibrk)) begin
      if (off % 4 == 0) model_iba[off / 4] = data;
      if (off % 4 == 1) model_ibm[off / 4] = data;
      if (off % 4 == 2) model_ibc[off / 4] = data;
    end
  endtask

  // The previous read response is a single-cycle pulse, so rvalid is low here.
  task automatic read_reg(input reg_addr_t addr, output word_t data);
    @(negedge core_clock);
    check("rvalid_idle", 32'd0, bus_rvalid);
    bus_valid = 1'b1;
    bus_write = 1'b0;
    bus_addr  = addr;
    @(negedge core_clock);
    bus_valid = 1'b0;
    while (!bus_rvalid) @(negedge core_clock);
    data = bus_rdata;
  endtask

  task automatic verify_reg(input string name, input reg_addr_t addr);
    word_t data;
    read_reg(addr, data);
    check(name, reg_value(addr), data);
  endtask

  // Capture, shift len bits LSB first while collecting tdo, then update.
  task automatic scan_chain(input ir_t ir, input int len, input word_t din, output word_t dout);
    dout = '0;
    @(negedge core_clock);
    jtag_ir = ir;
    tap_capture = 1'b1;
    @(negedge core_clock);
    tap_capture = 1'b0;
    for (int i = 0; i < len; i++) begin
      dout[i] = tdo;
      tap_shift = 1'b1;
      tdi = din[i];
      @(negedge core_clock);
    end
    tap_shift = 1'b0;
    tap_update = 1'b1;
    @(negedge core_clock);
    tap_update = 1'b0;
    if (ir == ir_data) p2c = din;
    if (ir == ir_control) ctl = din;
  endtask

  // Expected pulses and sticky status follow the inputs seen at each edge.
  always @(posedge core_clock) begin
    logic [1:0] h;
    logic brk, trc;
    logic [num_ibrk-1:0] set_bits, clr_bits;
    brk = 1'b0;
    trc = 1'b0;
    for (int n = 0; n < num_ibrk; n++) begin
      h = fetch_valid ? chan_hit(n, fetch_addr) : 2'b00;
      brk = brk | h[0];
      trc = trc | h[1];
      set_bits[n] = |h;
    end
    clr_bits = (bus_valid && bus_write && bus_addr == reg_ibs) ? bus_wdata[num_ibrk-1:0] : '0;
    if (rst) begin
      exp_hit   <= 2'b00;
      model_ibs <= '0;
    end else begin
      exp_hit   <= {trc, brk};
      model_ibs <= (model_ibs & ~clr_bits) | set_bits;
    end
  end

  always @(negedge core_clock) begin
    if (!rst) begin
      check("break_hit", exp_hit[0], break_hit);
      check("trace_hit", exp_hit[1], trace_hit);
    end
  end

  initial begin
    #(budget_cycles * 20);
    $display("Timeout: the tests did not finish within %0d cycles.", budget_cycles);
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  initial begin
    word_t d, dout;
    int ch;
    rst = 1'b1;
    {bus_valid, bus_write, fetch_valid, tap_capture, tap_shift, tap_update, tdi} = '0;
    bus_addr = '0;
    bus_wdata = '0;
    fetch_addr = '0;
    jtag_ir = ir_idcode;
    p2c = '0;
    c2p = '0;
    ctl = '0;
    for (int n = 0; n < num_ibrk; n++) begin
      model_iba[n] = '0;
      model_ibm[n] = '0;
      model_ibc[n] = '0;
    end
    repeat (10) @(posedge core_clock);
    @(negedge core_clock);
    rst = 1'b0;

    scan_chain(ir_idcode, 32, next_rand(), dout);
    check("idcode_scan", ejtag_idcode, dout);
    verify_reg("idcode_read", reg_id);

    d = next_rand();
    scan_chain(ir_data, 32, d, dout);
    verify_reg("mailbox_to_core", reg_probe_data);
    d = next_rand();
    write_reg(reg_probe_data, d);
    scan_chain(ir_data, 32, next_rand(), dout);
    check("mailbox_to_probe", c2p, dout);

    d = next_rand();
    scan_chain(ir_control, 32, d, dout);
    check("probe_en", d[ctl_bit_probe_en], probe_en);
    check("debug_int", d[ctl_bit_dint], debug_int);
    verify_reg("probe_status", reg_probe_status);
    scan_chain(ir_control, 32, next_rand(), dout);
    check("control_readback", d, dout);

    // Channel 0 always breaks and channel 1 always traces.
    for (int n = 0; n < num_ibrk; n++) begin
      write_reg(reg_ib_base + 6'(4 * n), next_rand());
      write_reg(reg_ib_base + 6'(4 * n + 1), next_rand() & next_rand());
      write_reg(reg_ib_base + 6'(4 * n + 2), next_rand() | 32'h1 | (32'h2 << n));
    end
    for (int i = 0; i < num_fetch; i++) begin
      @(negedge core_clock);
      ch = i % 4 / 2;
      fetch_valid = (next_rand() & 32'h3) != 0;
      fetch_addr = (i % 2 == 1) ? model_iba[ch] ^ (next_rand() & model_ibm[ch]) : next_rand();
    end
    @(negedge core_clock);
    fetch_valid = 1'b0;
    @(negedge core_clock);

    verify_reg("ibs_sticky", reg_ibs);
    write_reg(reg_ibs, 32'h1);
    verify_reg("ibs_clear_one", reg_ibs);
    write_reg(reg_ibs, '1);
    verify_reg("ibs_clear_all", reg_ibs);
    for (int n = 0; n < num_ibrk; n++) begin
      for (int s = 0; s < 4; s++) begin
        verify_reg($sformatf("ib_readback_%0d_%0d", n, s), reg_ib_base + 6'(4 * n + s));
      end
    end
    foreach (unmapped[i]) verify_reg($sformatf("unmapped_%h", unmapped[i]), unmapped[i]);

    d = next_rand();
    scan_chain(5'h1f, 32, d, dout);
    check("bypass", {d[30:0], 1'b0}, dout);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/ejtag_pkg.sv
src/ejtag_scan.sv
src/ejtag_pmatch.sv
src/ejtag_dataout.sv
src/ejtag.sv
bench/ejtag_tb.sv

// File: Bender.yml
package:
  name: ejtag

sources:
  - src/ejtag_pkg.sv
  - src/ejtag_scan.sv
  - src/ejtag_pmatch.sv
  - src/ejtag_dataout.sv
  - src/ejtag.sv
  - target: test
    files:
      - bench/ejtag_tb.sv
